//--- verilog/uart_pkg.sv
package uart_pkg;

  // ########################################
  // frame format
  // ########################################

  localparam int WORD_LEN   = 8;   // data bits per frame
  localparam int OVERSAMPLE = 16;  // ticks per bit cell

  // ########################################
  // register map
  // ########################################

  localparam int                DIV_W     = 16;
  localparam logic [DIV_W-1:0]  DIV_RESET = 16'd3;
  localparam int                ADDR_W    = 2;

  localparam logic [ADDR_W-1:0] A_DIV    = 2'd0;  // r/w baud divisor
  localparam logic [ADDR_W-1:0] A_TXDATA = 2'd1;  // write starts a frame
  localparam logic [ADDR_W-1:0] A_RXDATA = 2'd2;  // last received byte
  localparam logic [ADDR_W-1:0] A_STATUS = 2'd3;  // sticky flags

  typedef enum logic [2:0] {
    x_IDLE,
    x_START,
    x_WAIT,
    x_SHIFT,
    x_STOP
  } xmit_state_t;

  typedef enum logic [1:0] {
    r_IDLE,
    r_START,
    r_DATA,
    r_STOP
  } rec_state_t;

  // read back at A_STATUS[4:0], tx_busy on top
  typedef struct packed {
    logic tx_busy;
    logic rx_valid;
    logic rx_frame_err;
    logic rx_overrun;
    logic tx_drop;
  } uart_status_t;

endpackage

//--- verilog/baud_tick_gen.sv
`timescale 1ns/1ps

module baud_tick_gen (
  input  logic                       sys_clk,
  input  logic                       sys_rst_l,
  input  logic [uart_pkg::DIV_W-1:0] divisor,
  output logic                       tick
);

  logic [uart_pkg::DIV_W-1:0] cnt;

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      cnt <= '0;
    end else if (cnt == '0) begin
      cnt <= divisor;  // one tick every divisor+1 clocks
    end else begin
      cnt <= cnt - 1'b1;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      tick <= 1'b0;
    end else begin
      tick <= (cnt == '0);
    end
  end

  // a zero reload two clocks back is the only way to get back-to-back ticks
  a_tick_single : assert property (
    @(posedge sys_clk) disable iff (!sys_rst_l)
    (divisor != '0) && ($past(divisor, 2) != '0) |-> !(tick && $past(tick))
  );

endmodule

//--- verilog/uart_cfg_regs.sv
`timescale 1ns/1ps

module uart_cfg_regs (
  input  logic                        sys_clk,
  input  logic                        sys_rst_l,
  input  logic                        reg_wr,
  input  logic                        reg_rd,
  input  logic [uart_pkg::ADDR_W-1:0] reg_addr,
  input  logic [15:0]                 reg_wdata,
  output logic [15:0]                 reg_rdata,
  output logic [uart_pkg::DIV_W-1:0]  divisor,
  output logic                        xmit,
  output logic [uart_pkg::WORD_LEN-1:0] xmit_data,
  input  logic                        xmit_done,
  input  logic                        rec_strobe,
  input  logic                        rec_frame_err,
  input  logic [uart_pkg::WORD_LEN-1:0] rec_data
);

  uart_pkg::uart_status_t        status;
  logic [uart_pkg::WORD_LEN-1:0] rx_hold;
  logic                          wr_div;
  logic                          wr_tx;
  logic                          rd_rx;
  logic                          rd_status;

  assign wr_div    = reg_wr && (reg_addr == uart_pkg::A_DIV);
  assign wr_tx     = reg_wr && (reg_addr == uart_pkg::A_TXDATA);
  assign rd_rx     = reg_rd && (reg_addr == uart_pkg::A_RXDATA);
  assign rd_status = reg_rd && (reg_addr == uart_pkg::A_STATUS);

  assign xmit      = wr_tx && xmit_done;  // busy writes never reach the transmitter
  assign xmit_data = reg_wdata[uart_pkg::WORD_LEN-1:0];

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      divisor <= uart_pkg::DIV_RESET;
    end else if (wr_div) begin
      divisor <= reg_wdata[uart_pkg::DIV_W-1:0];
    end
  end

  always_ff @(posedge sys_clk) begin
    if (rec_strobe) begin
      rx_hold <= rec_data;  // newest byte wins
    end
  end

  // ########################################
  // status flags, sets override clears
  // ########################################

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      status <= '0;
    end else begin
      status.tx_busy <= !xmit_done;
      if (rd_rx) begin
        status.rx_valid <= 1'b0;
      end
      if (rd_status) begin
        status.rx_frame_err <= 1'b0;
        status.rx_overrun   <= 1'b0;
        status.tx_drop      <= 1'b0;
      end
      if (rec_strobe) begin
        status.rx_valid <= 1'b1;
        if (status.rx_valid && !rd_rx) begin
          status.rx_overrun <= 1'b1;  // old byte lost
        end
        if (rec_frame_err) begin
          status.rx_frame_err <= 1'b1;
        end
      end
      if (wr_tx && !xmit_done) begin
        status.tx_drop <= 1'b1;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      reg_rdata <= '0;
    end else if (reg_rd) begin
      case (reg_addr)
        uart_pkg::A_DIV:    reg_rdata <= 16'(divisor);
        uart_pkg::A_RXDATA: reg_rdata <= 16'(rx_hold);
        uart_pkg::A_STATUS: reg_rdata <= 16'(status);  // pre-clear value
        default:            reg_rdata <= '0;
      endcase
    end
  end

  // the transmitter must be idle and must leave idle right after the pulse
  a_xmit_idle : assert property (
    @(posedge sys_clk) disable iff (!sys_rst_l)
    xmit |-> xmit_done ##1 !xmit_done
  );

endmodule

//--- verilog/u_xmit.sv
`timescale 1ns/1ps

module u_xmit (
  input  logic                          sys_clk,
  input  logic                          sys_rst_l,
  input  logic                          tick,
  input  logic                          xmit,
  input  logic [uart_pkg::WORD_LEN-1:0] xmit_data,
  output logic                          uart_tx,
  output logic                          xmit_done
);

  typedef enum logic [1:0] {
    SEL_START,
    SEL_DATA,
    SEL_STOP
  } line_sel_t;

  uart_pkg::xmit_state_t                   state;
  uart_pkg::xmit_state_t                   next_state;
  logic [$clog2(uart_pkg::OVERSAMPLE)-1:0] cell_cnt;
  logic [uart_pkg::WORD_LEN-1:0]           shift_reg;
  logic [$clog2(uart_pkg::WORD_LEN):0]     bit_cnt;
  logic                                    load_shift;
  logic                                    shift_ena;
  logic                                    bit_ena;
  logic                                    done_in;
  logic                                    cell_last;
  logic                                    wait_last;
  line_sel_t                               line_sel;
  logic                                    line_bit;

  assign cell_last = (int'(cell_cnt) == uart_pkg::OVERSAMPLE - 1);
  assign wait_last = (int'(cell_cnt) == uart_pkg::OVERSAMPLE - 2);  // x_SHIFT takes the last tick

  always_comb begin
    case (line_sel)
      SEL_START: line_bit = 1'b0;
      SEL_DATA:  line_bit = shift_reg[0];
      default:   line_bit = 1'b1;
    endcase
  end

  // line only moves on a tick so every cell is exactly 16 ticks
  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      uart_tx <= 1'b1;
    end else if (tick) begin
      uart_tx <= line_bit;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      cell_cnt <= '0;
    end else if (state == uart_pkg::x_IDLE) begin
      cell_cnt <= '0;
    end else if (tick) begin
      cell_cnt <= cell_cnt + 1'b1;  // wraps at cell end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (load_shift) begin
      shift_reg <= xmit_data;
    end else if (shift_ena) begin
      shift_reg <= {1'b1, shift_reg[uart_pkg::WORD_LEN-1:1]};  // fill with ones
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      bit_cnt <= '0;
    end else if (state == uart_pkg::x_IDLE) begin
      bit_cnt <= '0;
    end else if (bit_ena) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // ########################################
  // bit-cell state machine
  // ########################################

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      state     <= uart_pkg::x_IDLE;
      xmit_done <= 1'b1;
    end else begin
      state     <= next_state;
      xmit_done <= done_in;
    end
  end

  always_comb begin
    next_state = state;
    load_shift = 1'b0;
    shift_ena  = 1'b0;
    bit_ena    = 1'b0;
    done_in    = 1'b0;
    line_sel   = SEL_STOP;
    case (state)
      uart_pkg::x_IDLE: begin
        if (xmit) begin
          next_state = uart_pkg::x_START;
          load_shift = 1'b1;
        end else begin
          done_in = 1'b1;
        end
      end
      uart_pkg::x_START: begin
        line_sel = SEL_START;
        if (tick && cell_last) begin
          next_state = uart_pkg::x_WAIT;
        end
      end
      uart_pkg::x_WAIT: begin
        line_sel = SEL_DATA;
        if (tick && wait_last) begin
          next_state = uart_pkg::x_SHIFT;
          bit_ena    = 1'b1;  // one more bit sent
        end
      end
      uart_pkg::x_SHIFT: begin
        line_sel = SEL_DATA;
        if (tick) begin
          shift_ena = 1'b1;
          if (int'(bit_cnt) == uart_pkg::WORD_LEN) begin
            next_state = uart_pkg::x_STOP;
          end else begin
            next_state = uart_pkg::x_WAIT;
          end
        end
      end
      uart_pkg::x_STOP: begin
        line_sel = SEL_STOP;
        if (tick && cell_last) begin
          next_state = uart_pkg::x_IDLE;
          done_in    = 1'b1;
        end
      end
      default: next_state = uart_pkg::x_IDLE;
    endcase
  end

  // line lags the state by one tick, so skip the first tick of x_START
  a_start_low : assert property (
    @(posedge sys_clk) disable iff (!sys_rst_l)
    (state == uart_pkg::x_START) && (cell_cnt != '0) |-> !uart_tx
  );

endmodule

//--- verilog/u_rec.sv
`timescale 1ns/1ps

module u_rec (
  input  logic                          sys_clk,
  input  logic                          sys_rst_l,
  input  logic                          tick,
  input  logic                          uart_rx,
  output logic [uart_pkg::WORD_LEN-1:0] rec_data,
  output logic                          rec_strobe,
  output logic                          rec_frame_err
);

  uart_pkg::rec_state_t                    state;
  uart_pkg::rec_state_t                    next_state;
  logic                                    rx_meta;
  logic                                    rx_sync;
  logic                                    rx_last;
  logic                                    rx_fall;
  logic [$clog2(uart_pkg::OVERSAMPLE)-1:0] cell_cnt;
  logic [$clog2(uart_pkg::WORD_LEN)-1:0]   bit_cnt;
  logic                                    mid_cell;
  logic                                    end_cell;
  logic                                    cnt_clr;
  logic                                    bit_take;
  logic                                    stop_take;

  // ########################################
  // input synchronizer
  // ########################################

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_last <= 1'b1;
    end else begin
      rx_meta <= uart_rx;
      rx_sync <= rx_meta;
      rx_last <= rx_sync;  // for edge detect
    end
  end

  assign rx_fall  = rx_last && !rx_sync;
  assign mid_cell = tick && (int'(cell_cnt) == uart_pkg::OVERSAMPLE / 2 - 1);
  assign end_cell = tick && (int'(cell_cnt) == uart_pkg::OVERSAMPLE - 1);

  // realigned at mid start bit, so end_cell lands mid-bit afterwards
  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      cell_cnt <= '0;
    end else if ((state == uart_pkg::r_IDLE) || cnt_clr) begin
      cell_cnt <= '0;
    end else if (tick) begin
      cell_cnt <= cell_cnt + 1'b1;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      bit_cnt <= '0;
    end else if (state == uart_pkg::r_IDLE) begin
      bit_cnt <= '0;
    end else if (bit_take) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (bit_take) begin
      rec_data <= {rx_sync, rec_data[uart_pkg::WORD_LEN-1:1]};  // lsb first
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      rec_strobe    <= 1'b0;
      rec_frame_err <= 1'b0;
    end else begin
      rec_strobe    <= stop_take;
      rec_frame_err <= stop_take && !rx_sync;  // low stop bit
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      state <= uart_pkg::r_IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    cnt_clr    = 1'b0;
    bit_take   = 1'b0;
    stop_take  = 1'b0;
    case (state)
      uart_pkg::r_IDLE: begin
        if (rx_fall) begin
          next_state = uart_pkg::r_START;
        end
      end
      uart_pkg::r_START: begin
        if (mid_cell) begin
          if (!rx_sync) begin
            next_state = uart_pkg::r_DATA;
            cnt_clr    = 1'b1;
          end else begin
            next_state = uart_pkg::r_IDLE;  // glitch, not a start bit
          end
        end
      end
      uart_pkg::r_DATA: begin
        if (end_cell) begin
          bit_take = 1'b1;
          if (int'(bit_cnt) == uart_pkg::WORD_LEN - 1) begin
            next_state = uart_pkg::r_STOP;
          end
        end
      end
      uart_pkg::r_STOP: begin
        if (end_cell) begin
          stop_take  = 1'b1;
          next_state = uart_pkg::r_IDLE;
        end
      end
      default: next_state = uart_pkg::r_IDLE;
    endcase
  end

  a_strobe_pulse : assert property (
    @(posedge sys_clk) disable iff (!sys_rst_l)
    rec_strobe |=> !rec_strobe
  );

endmodule

//--- verilog/uart_top.sv
`timescale 1ns/1ps

module uart_top (
  input  logic                        sys_clk,
  input  logic                        sys_rst_l,
  input  logic                        reg_wr,
  input  logic                        reg_rd,
  input  logic [uart_pkg::ADDR_W-1:0] reg_addr,
  input  logic [15:0]                 reg_wdata,
  output logic [15:0]                 reg_rdata,
  output logic                        uart_tx,
  input  logic                        uart_rx
);

  logic [uart_pkg::DIV_W-1:0]    divisor;
  logic                          tick;
  logic                          xmit;
  logic [uart_pkg::WORD_LEN-1:0] xmit_data;
  logic                          xmit_done;
  logic [uart_pkg::WORD_LEN-1:0] rec_data;
  logic                          rec_strobe;
  logic                          rec_frame_err;

  uart_cfg_regs regs (
    .sys_clk       (sys_clk),
    .sys_rst_l     (sys_rst_l),
    .reg_wr        (reg_wr),
    .reg_rd        (reg_rd),
    .reg_addr      (reg_addr),
    .reg_wdata     (reg_wdata),
    .reg_rdata     (reg_rdata),
    .divisor       (divisor),
    .xmit          (xmit),
    .xmit_data     (xmit_data),
    .xmit_done     (xmit_done),
    .rec_strobe    (rec_strobe),
    .rec_frame_err (rec_frame_err),
    .rec_data      (rec_data)
  );

  baud_tick_gen baud (
    .sys_clk   (sys_clk),
    .sys_rst_l (sys_rst_l),
    .divisor   (divisor),
    .tick      (tick)
  );

  // tx and rx share one tick
  u_xmit xmtr (
    .sys_clk   (sys_clk),
    .sys_rst_l (sys_rst_l),
    .tick      (tick),
    .xmit      (xmit),
    .xmit_data (xmit_data),
    .uart_tx   (uart_tx),
    .xmit_done (xmit_done)
  );

  u_rec rcvr (
    .sys_clk       (sys_clk),
    .sys_rst_l     (sys_rst_l),
    .tick          (tick),
    .uart_rx       (uart_rx),
    .rec_data      (rec_data),
    .rec_strobe    (rec_strobe),
    .rec_frame_err (rec_frame_err)
  );

endmodule

//--- verif/uart_tb.sv
`timescale 1ns/1ps

module uart_tb;

  typedef enum logic [1:0] {
    MODE_LOOP,
    MODE_BADSTOP,
    MODE_DOUBLE,
    MODE_OVERRUN
  } frame_mode_t;

  typedef struct packed {
    logic [15:0] div;
    logic [7:0]  data;
    frame_mode_t mode;
    logic [4:0]  exp_status;  // bit 4 tx_busy stays zero
  } test_row_t;

  localparam int NUM_ROWS = 12;

  logic                        sys_clk;
  logic                        sys_rst_l;
  logic                        reg_wr;
  logic                        reg_rd;
  logic [uart_pkg::ADDR_W-1:0] reg_addr;
  logic [15:0]                 reg_wdata;
  logic [15:0]                 reg_rdata;
  logic                        uart_tx;
  logic                        uart_rx;
  logic                        inject_on;
  logic                        inject_bit;

  test_row_t table_rows [NUM_ROWS];
  int        errors;
  int        cycle_cnt;
  int        cycle_limit;

  uart_top UUT (
    .sys_clk   (sys_clk),
    .sys_rst_l (sys_rst_l),
    .reg_wr    (reg_wr),
    .reg_rd    (reg_rd),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .uart_tx   (uart_tx),
    .uart_rx   (uart_rx)
  );

  assign uart_rx = inject_on ? inject_bit : uart_tx;  // loopback unless injecting

  always #10 sys_clk = ~sys_clk;

  always @(posedge sys_clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout, run went past %0d cycles, errors: %0d", cycle_limit, errors);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // ########################################
  // helpers
  // ########################################

  task automatic compare_value(input string name, input logic [15:0] got,
                               input logic [15:0] expected);
    if (got !== expected) begin
      errors++;
      $display("Mismatch %s: got 0x%h expected 0x%h", name, got, expected);
    end
  endtask

  task automatic reg_write(input logic [uart_pkg::ADDR_W-1:0] addr, input logic [15:0] data);
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge sys_clk);
    reg_wr    = 1'b0;
  endtask

  task automatic reg_read(input logic [uart_pkg::ADDR_W-1:0] addr, output logic [15:0] data);
    reg_rd   = 1'b1;
    reg_addr = addr;
    @(negedge sys_clk);
    reg_rd   = 1'b0;
    data     = reg_rdata;  // registered one cycle after the strobe
  endtask

  // reads STATUS until the masked bits match and ORs the flags it sees
  task automatic poll_status(input logic [4:0] mask, input logic [4:0] want,
                             input int max_reads, output logic [4:0] flags);
    logic [15:0] rd;
    int          n;
    flags = 5'h00;
    n     = 0;
    do begin
      reg_read(uart_pkg::A_STATUS, rd);
      flags = flags | rd[4:0];
      n++;
    end while (((rd[4:0] & mask) != want) && (n < max_reads));
    if ((rd[4:0] & mask) != want) begin
      errors++;
      $display("STATUS did not reach the awaited state within %0d reads", n);
    end
    flags = flags & 5'h0f;
  endtask

  task automatic check_frame(input logic [7:0] exp_byte, input int t_bit);
    logic [7:0] got;
    int         n;
    int         high_cnt;
    n        = 0;
    high_cnt = 0;
    while ((uart_tx !== 1'b0) && (n < t_bit)) begin
      @(negedge sys_clk);
      n++;
    end
    if (uart_tx !== 1'b0) begin
      errors++;
      $display("no start bit on uart_tx within %0d cycles of the write", t_bit);
    end else begin
      for (n = 1; n < t_bit; n++) begin
        @(negedge sys_clk);
        if (uart_tx !== 1'b0) begin
          high_cnt++;
        end
      end
      if (high_cnt != 0) begin
        errors++;
        $display("start bit went high in %0d of its %0d cycles", high_cnt, t_bit);
      end
      @(negedge sys_clk);
      compare_value("uart_tx first cycle after start bit", 16'(uart_tx), 16'(exp_byte[0]));
      repeat (t_bit / 2) @(negedge sys_clk);  // mid bit 0
      got[0] = uart_tx;
      for (n = 1; n < 8; n++) begin
        repeat (t_bit) @(negedge sys_clk);
        got[n] = uart_tx;
      end
      compare_value("uart_tx serial byte", 16'(got), 16'(exp_byte));
      repeat (t_bit) @(negedge sys_clk);
      compare_value("uart_tx stop bit", 16'(uart_tx), 16'h0001);
    end
  endtask

  task automatic inject_frame(input logic [7:0] data, input logic stop_bit, input int t_bit);
    logic [9:0] frame;
    int         i;
    frame     = {stop_bit, data, 1'b0};
    inject_on = 1'b1;
    for (i = 0; i < 10; i++) begin
      inject_bit = frame[i];
      repeat (t_bit) @(negedge sys_clk);
    end
    inject_bit = 1'b1;  // idle cell before handing the line back
    repeat (t_bit) @(negedge sys_clk);
    inject_on = 1'b0;
  endtask

  function automatic int frames_in(input frame_mode_t mode);
    if (mode == MODE_OVERRUN) begin
      return 2;
    end
    return 1;
  endfunction

  // ########################################
  // stimulus table
  // ########################################

  task automatic load_table();
    int i;
    table_rows[0] = '{16'd3, 8'h55, MODE_LOOP,    5'h08};
    table_rows[1] = '{16'd0, 8'ha3, MODE_LOOP,    5'h08};
    table_rows[2] = '{16'd1, 8'h0f, MODE_LOOP,    5'h08};
    table_rows[3] = '{16'd5, 8'hf0, MODE_LOOP,    5'h08};
    table_rows[4] = '{16'd1, 8'h00, MODE_LOOP,    5'h08};
    table_rows[5] = '{16'd2, 8'hff, MODE_LOOP,    5'h08};
    table_rows[6] = '{16'd3, 8'h96, MODE_DOUBLE,  5'h09};  // rx_valid, tx_drop
    table_rows[7] = '{16'd1, 8'h3c, MODE_BADSTOP, 5'h0c};  // rx_valid, frame err
    table_rows[8] = '{16'd2, 8'h81, MODE_OVERRUN, 5'h0a};  // rx_valid, overrun
    for (i = 9; i < NUM_ROWS; i++) begin
      table_rows[i] = '{16'(2 * (i - 9)), 8'($urandom()), MODE_LOOP, 5'h08};
    end
  endtask

  task automatic run_row(input test_row_t row);
    int          t_bit;
    logic [15:0] rd;
    logic [4:0]  flags;
    logic [4:0]  first_flags;
    t_bit = uart_pkg::OVERSAMPLE * (int'(row.div) + 1);
    flags = 5'h00;
    reg_write(uart_pkg::A_DIV, row.div);
    case (row.mode)
      MODE_LOOP: begin
        reg_write(uart_pkg::A_TXDATA, {8'h00, row.data});
        check_frame(row.data, t_bit);
        poll_status(5'h10, 5'h00, t_bit, flags);
      end
      MODE_DOUBLE: begin
        reg_write(uart_pkg::A_TXDATA, {8'h00, row.data});
        fork
          check_frame(row.data, t_bit);
          reg_write(uart_pkg::A_TXDATA, {8'h00, ~row.data});  // lands on a busy tx
        join
        poll_status(5'h10, 5'h00, t_bit, flags);
      end
      MODE_BADSTOP: begin
        inject_frame(row.data, 1'b0, t_bit);
        poll_status(5'h08, 5'h08, 4, flags);
      end
      default: begin
        reg_write(uart_pkg::A_TXDATA, {8'h00, ~row.data});
        check_frame(~row.data, t_bit);
        poll_status(5'h10, 5'h00, t_bit, first_flags);
        compare_value("status after first frame", 16'(first_flags), 16'h0008);
        reg_write(uart_pkg::A_TXDATA, {8'h00, row.data});
        check_frame(row.data, t_bit);
        poll_status(5'h10, 5'h00, t_bit, flags);
      end
    endcase
    compare_value("status flags", 16'(flags), 16'(row.exp_status));
    reg_read(uart_pkg::A_RXDATA, rd);
    compare_value("rxdata", rd, {8'h00, row.data});
    reg_read(uart_pkg::A_STATUS, rd);
    compare_value("status after clear", rd, 16'h0000);
  endtask

  // ########################################
  // main sequence
  // ########################################

  initial begin
    int          i;
    logic [15:0] rd;
    sys_clk     = 1'b0;
    sys_rst_l   = 1'b0;
    reg_wr      = 1'b0;
    reg_rd      = 1'b0;
    reg_addr    = '0;
    reg_wdata   = 16'h0000;
    inject_on   = 1'b0;
    inject_bit  = 1'b1;
    errors      = 0;
    cycle_cnt   = 0;
    void'($urandom(73));
    load_table();
    cycle_limit = 200;
    for (i = 0; i < NUM_ROWS; i++) begin
      cycle_limit += frames_in(table_rows[i].mode) * 12 * uart_pkg::OVERSAMPLE *
                     (int'(table_rows[i].div) + 1);
    end

    repeat (4) @(negedge sys_clk);
    sys_rst_l = 1'b1;
    compare_value("uart_tx after reset", 16'(uart_tx), 16'h0001);
    reg_read(uart_pkg::A_STATUS, rd);
    compare_value("status after reset", rd, 16'h0000);
    reg_read(uart_pkg::A_DIV, rd);
    compare_value("divisor after reset", rd, 16'h0003);

    for (i = 0; i < NUM_ROWS; i++) begin
      run_row(table_rows[i]);
    end

    $display("%0d rows run in %0d cycles, errors: %0d", NUM_ROWS, cycle_cnt, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- uart_link.f
verilog/uart_pkg.sv
verilog/baud_tick_gen.sv
verilog/uart_cfg_regs.sv
verilog/u_xmit.sv
verilog/u_rec.sv
verilog/uart_top.sv
verif/uart_tb.sv

//--- Makefile
# Verilator build and run for the UART testbench

VERILATOR ?= verilator
TOP       ?= uart_tb
FILELIST  ?= uart_link.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= RESULT: FAIL

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the fail message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
